// File: load_unit_top.f
hw/mem_pkg.sv
hw/lsu_pkg.sv
hw/load_skid_buffer.sv
hw/load_fifo.sv
hw/load_queue.sv
hw/load_align.sv
hw/load_unit_top.sv
testbench/tb_load_unit.sv

// File: Makefile
TOP = tb_load_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f load_unit_top.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: testbench/tb_load_unit.sv
// Load unit testbench
module tb_load_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;
    import mem_pkg::*;

    localparam word_t IO_XOR     = 32'h5a5a_0f0f;
    localparam int    WAIT_LIMIT = 300;

    logic        core_clock_i;
    logic        rst_n_i;
    logic        flush_i;
    logic        issue_valid_i;
    load_req_t   issue_req_i;
    logic        issue_busy_o;
    logic        hit_i;
    line_addr_t  line_addr_o;
    ram_addr_t   ram_addr_o;
    dword_t      ram_data_i = '0;
    logic [29:0] conflict_addr_o;
    byte_mask_t  conflict_mask_o;
    logic        conflict_valid_i;
    logic        conflict_ok_i;
    word_t       conflict_data_i;
    oldest_tag_t oldest_tag_i;
    logic        store_buf_empty_i;
    logic        mem_req_o;
    mem_req_t    mem_req_info_o;
    logic        mem_ack_i = 1'b0;
    word_t       mem_data_i = '0;
    logic        wb_valid_o;
    load_wb_t    wb_o;

    logic [7:0]  mem_bytes [4096];
    logic        resident [32];
    ram_addr_t   rd_addr_q;
    logic [15:0] lfsr_q;
    int          resp_delay;
    int          errors;
    mem_req_t    req_log [$];

    load_unit_top #(
        .WEAK_DEPTH   (8),
        .STRONG_DEPTH (4)
    ) UUT (
        .core_clock_i      (core_clock_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .issue_valid_i     (issue_valid_i),
        .issue_req_i       (issue_req_i),
        .issue_busy_o      (issue_busy_o),
        .hit_i             (hit_i),
        .line_addr_o       (line_addr_o),
        .ram_addr_o        (ram_addr_o),
        .ram_data_i        (ram_data_i),
        .conflict_addr_o   (conflict_addr_o),
        .conflict_mask_o   (conflict_mask_o),
        .conflict_valid_i  (conflict_valid_i),
        .conflict_ok_i     (conflict_ok_i),
        .conflict_data_i   (conflict_data_i),
        .oldest_tag_i      (oldest_tag_i),
        .store_buf_empty_i (store_buf_empty_i),
        .mem_req_o         (mem_req_o),
        .mem_req_info_o    (mem_req_info_o),
        .mem_ack_i         (mem_ack_i),
        .mem_data_i        (mem_data_i),
        .wb_valid_o        (wb_valid_o),
        .wb_o              (wb_o)
    );

    initial begin
        core_clock_i = 1'b0;
        forever #5 core_clock_i = ~core_clock_i;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic int lfsr_take(int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic logic [7:0] fill_byte(logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    function automatic word_t mem_word(addr_t a);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = mem_bytes[{a[11:2], 2'b00} + b];
        end
        return w;
    endfunction

    // Size from op bits 1:0, zero extension when op bit 2 is set
    function automatic word_t extend(load_op_t op, logic [1:0] off, word_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (op[1:0])
            2'd0: return op[2] ? {24'd0, b} : {{24{b[7]}}, b};
            2'd1: return op[2] ? {16'd0, h} : {{16{h[15]}}, h};
            default: return w;
        endcase
    endfunction

    // Cache and memory models
    assign hit_i = resident[line_addr_o[4:0]] && (line_addr_o[24:5] == '0);

    always @(posedge core_clock_i) begin
        rd_addr_q <= ram_addr_o;
    end

    always @(negedge core_clock_i) begin
        for (int b = 0; b < 8; b++) begin
            ram_data_i[8*b +: 8] <= mem_bytes[int'(rd_addr_q) * 8 + b];
        end
    end

    // Four-phase responder, refill makes the line resident at ack
    always @(negedge core_clock_i) begin
        if (!rst_n_i) begin
            mem_ack_i  <= 1'b0;
            mem_data_i <= '0;
            resp_delay <= -1;
            lfsr_q     = 16'd12426;
            for (int i = 0; i < 32; i++) begin
                resident[i] <= (i < 16);
            end
        end else if (mem_req_o && !mem_ack_i) begin
            if (resp_delay < 0) begin
                req_log.push_back(mem_req_info_o);
                resp_delay <= mem_req_info_o.uncached ? 2 : 3 + lfsr_take(3);
            end else if (resp_delay == 0) begin
                mem_ack_i  <= 1'b1;
                resp_delay <= -1;
                if (mem_req_info_o.uncached) begin
                    mem_data_i <= mem_req_info_o.addr ^ IO_XOR;
                end else begin
                    resident[mem_req_info_o.addr[11:7]] <= 1'b1;
                end
            end else begin
                resp_delay <= resp_delay - 1;
            end
        end else if (mem_ack_i && !mem_req_o) begin
            mem_ack_i <= 1'b0;
        end
    end

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic issue_load(load_req_t req);
        int t;
        @(negedge core_clock_i);
        issue_valid_i = 1'b1;
        issue_req_i   = req;
        t = 0;
        while (issue_busy_o && t < WAIT_LIMIT) begin
            @(negedge core_clock_i);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            $display("issue port stayed busy, load never accepted");
            errors++;
        end else begin
            // Store buffer lookup follows the load at the queue input
            #1;
            compare_value("conflict_addr_o", 32'(conflict_addr_o), 32'(req.addr[31:2]));
            compare_value("conflict_mask_o", 32'(conflict_mask_o), 32'(req.mask));
        end
        @(negedge core_clock_i);
        issue_valid_i = 1'b0;
    endtask

    // Latency counts falling edges after the accepting edge
    task automatic await_writeback(load_req_t req, word_t exp, int exp_lat);
        int       lat;
        load_wb_t wb;
        lat = 1;
        while (!wb_valid_o && lat < WAIT_LIMIT) begin
            @(negedge core_clock_i);
            lat++;
        end
        wb = wb_o;
        if (!wb_valid_o) begin
            $display("timeout waiting for writeback of rob %h", req.rob);
            errors++;
        end else begin
            compare_value("wb_o.rob", 32'(wb.rob), 32'(req.rob));
            compare_value("wb_o.dest", 32'(wb.dest), 32'(req.dest));
            compare_value("wb_o.data", wb.data, exp);
            compare_value("wb_o.wr_en", 32'(wb.wr_en), 32'(req.dest != '0));
            if (exp_lat > 0 && lat != exp_lat) begin
                $display("writeback of rob %h came %0d cycles after acceptance, not %0d",
                         req.rob, lat, exp_lat);
                errors++;
            end
        end
        @(negedge core_clock_i);
    endtask

    function automatic load_req_t make_req(rob_tag_t rob, load_op_t op, addr_t a, preg_t dest);
        byte_mask_t m;
        case (op[1:0])
            2'd0: m = 4'b0001 << a[1:0];
            2'd1: m = 4'b0011 << a[1:0];
            default: m = 4'b1111;
        endcase
        return '{rob: rob, op: op, addr: a, dest: dest, mask: m};
    endfunction

    task automatic controls_low();
        compare_value("issue_busy_o", 32'(issue_busy_o), 0);
        compare_value("mem_req_o", 32'(mem_req_o), 0);
        compare_value("wb_valid_o", 32'(wb_valid_o), 0);
        compare_value("wb_wr_en_o", 32'(wb_o.wr_en), 0);
    endtask

    // Bytes below 0x180 are positive, from 0x180 on negative
    task automatic hit_loads();
        load_op_t  ops [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        load_req_t req;
        addr_t     a;
        int        n;
        n = 0;
        foreach (ops[i]) begin
            for (int k = 0; k < 8; k++) begin
                for (int off = 0; off < 4; off += (1 << ops[i][1:0])) begin
                    a   = 32'h170 + 4 * k + off;
                    req = make_req(6'(n), ops[i], a, 6'(k + 1));
                    issue_load(req);
                    await_writeback(req, extend(ops[i], a[1:0], mem_word(a)), 2);
                    n++;
                end
            end
        end
    endtask

    task automatic forwarded_loads();
        load_req_t req;
        word_t     exp;
        conflict_valid_i = 1'b1;
        conflict_ok_i    = 1'b1;
        conflict_data_i  = 32'ha1b2_c3d4;
        req       = make_req(6'h11, 3'd2, 32'h240, 6'd3);
        req.mask  = 4'b0110;
        exp       = mem_word(req.addr);
        exp[23:8] = 16'hb2c3;
        issue_load(req);
        await_writeback(req, exp, 2);
        conflict_valid_i = 1'b1;
        req = make_req(6'h12, 3'd0, 32'h245, 6'd4);
        issue_load(req);
        await_writeback(req, 32'hffff_ffc3, 2);
        conflict_valid_i = 1'b0;
        conflict_ok_i    = 1'b0;
    endtask

    task automatic miss_loads();
        load_req_t first;
        load_req_t second;
        req_log.delete();
        first  = make_req(6'd5, 3'd2, 32'h844, 6'd7);
        second = make_req(6'd6, 3'd5, 32'h906, 6'd8);
        issue_load(first);
        issue_load(second);
        await_writeback(first, mem_word(first.addr), 0);
        await_writeback(second, extend(3'd5, 2'd2, mem_word(second.addr)), 0);
        if (req_log.size() != 2) begin
            $display("expected two refill requests, saw %0d", req_log.size());
            errors++;
        end else begin
            compare_value("mem_req_info_o.addr", req_log[0].addr, 32'h800);
            compare_value("mem_req_info_o.uncached", 32'(req_log[0].uncached), 0);
            compare_value("mem_req_info_o.addr", req_log[1].addr, 32'h900);
            compare_value("mem_req_info_o.uncached", 32'(req_log[1].uncached), 0);
        end
    endtask

    task automatic io_load_ordering();
        load_req_t req;
        req_log.delete();
        oldest_tag_i      = 5'd7;
        store_buf_empty_i = 1'b1;
        req = make_req(6'h23, 3'd1, 32'h8000_0124, 6'd9);
        issue_load(req);
        for (int i = 0; i < 24; i++) begin
            // Tag matches for the second half, stores pending again
            if (i == 12) begin
                oldest_tag_i      = 5'd3;
                store_buf_empty_i = 1'b0;
            end
            @(negedge core_clock_i);
            if (mem_req_o) begin
                $display("I/O request raised before it was the oldest with stores drained");
                errors++;
            end
        end
        store_buf_empty_i = 1'b1;
        await_writeback(req, extend(3'd1, 2'd0, req.addr ^ IO_XOR), 0);
        if (req_log.size() != 1) begin
            $display("expected one I/O request, saw %0d", req_log.size());
            errors++;
        end else begin
            compare_value("mem_req_info_o.addr", req_log[0].addr, req.addr);
            compare_value("mem_req_info_o.uncached", 32'(req_log[0].uncached), 1);
        end
        oldest_tag_i = 5'd0;
    endtask

    task automatic dest_zero_load();
        load_req_t req;
        req = make_req(6'h2a, 3'd2, 32'h300, 6'd0);
        issue_load(req);
        await_writeback(req, mem_word(req.addr), 2);
    endtask

    task automatic flush_behind_miss();
        int t;
        issue_load(make_req(6'd10, 3'd2, 32'ha04, 6'd5));
        issue_load(make_req(6'd11, 3'd2, 32'ha08, 6'd6));
        flush_i = 1'b1;
        @(negedge core_clock_i);
        flush_i = 1'b0;
        for (int i = 0; i < 30; i++) begin
            @(negedge core_clock_i);
            if (wb_valid_o) begin
                $display("writeback seen after flush, rob %h", wb_o.rob);
                errors++;
            end
        end
        t = 0;
        while ((mem_req_o || mem_ack_i) && t < WAIT_LIMIT) begin
            @(negedge core_clock_i);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            $display("memory handshake did not finish after flush");
            errors++;
        end
        controls_low();
    endtask

    initial begin
        errors            = 0;
        rst_n_i           = 1'b0;
        flush_i           = 1'b0;
        issue_valid_i     = 1'b0;
        issue_req_i       = '0;
        conflict_valid_i  = 1'b0;
        conflict_ok_i     = 1'b0;
        conflict_data_i   = '0;
        oldest_tag_i      = 5'd0;
        store_buf_empty_i = 1'b1;
        for (int a = 0; a < 4096; a++) begin
            mem_bytes[a] = fill_byte(12'(a));
        end
        repeat (4) @(posedge core_clock_i);
        @(negedge core_clock_i);
        rst_n_i = 1'b1;
        controls_low();
        hit_loads();
        forwarded_loads();
        miss_loads();
        io_load_ordering();
        dest_zero_load();
        flush_behind_miss();
        $display("Checks failed: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hw/load_unit_top.sv
// Load unit top level
module load_unit_top #(
    parameter int WEAK_DEPTH   = 8,
    parameter int STRONG_DEPTH = 4
) (
    input  logic                 core_clock_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 issue_valid_i,
    input  lsu_pkg::load_req_t   issue_req_i,
    output logic                 issue_busy_o,
    input  logic                 hit_i,
    output mem_pkg::line_addr_t  line_addr_o,
    output mem_pkg::ram_addr_t   ram_addr_o,
    input  mem_pkg::dword_t      ram_data_i,
    output logic [29:0]          conflict_addr_o,
    output mem_pkg::byte_mask_t  conflict_mask_o,
    input  logic                 conflict_valid_i,
    input  logic                 conflict_ok_i,
    input  mem_pkg::word_t       conflict_data_i,
    input  lsu_pkg::oldest_tag_t oldest_tag_i,
    input  logic                 store_buf_empty_i,
    output logic                 mem_req_o,
    output mem_pkg::mem_req_t    mem_req_info_o,
    input  logic                 mem_ack_i,
    input  mem_pkg::word_t       mem_data_i,
    output logic                 wb_valid_o,
    output lsu_pkg::load_wb_t    wb_o
);
    import lsu_pkg::*;

    logic        skid_valid;
    load_req_t   skid_req;
    logic        queue_stall;
    load_stage_t stage;

    load_skid_buffer u_skid (
        .core_clock_i (core_clock_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .in_valid_i   (issue_valid_i),
        .in_req_i     (issue_req_i),
        .stall_i      (queue_stall),
        .busy_o       (issue_busy_o),
        .out_valid_o  (skid_valid),
        .out_req_o    (skid_req)
    );

    load_queue #(
        .WEAK_DEPTH   (WEAK_DEPTH),
        .STRONG_DEPTH (STRONG_DEPTH)
    ) u_queue (
        .core_clock_i      (core_clock_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .in_valid_i        (skid_valid),
        .in_req_i          (skid_req),
        .stall_o           (queue_stall),
        .hit_i             (hit_i),
        .line_addr_o       (line_addr_o),
        .ram_addr_o        (ram_addr_o),
        .conflict_addr_o   (conflict_addr_o),
        .conflict_mask_o   (conflict_mask_o),
        .conflict_valid_i  (conflict_valid_i),
        .conflict_ok_i     (conflict_ok_i),
        .conflict_data_i   (conflict_data_i),
        .oldest_tag_i      (oldest_tag_i),
        .store_buf_empty_i (store_buf_empty_i),
        .mem_req_o         (mem_req_o),
        .mem_req_info_o    (mem_req_info_o),
        .mem_ack_i         (mem_ack_i),
        .mem_data_i        (mem_data_i),
        .stage_o           (stage)
    );

    load_align u_align (
        .core_clock_i (core_clock_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .stage_i      (stage),
        .ram_data_i   (ram_data_i),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

endmodule

// File: hw/load_align.sv
// Load data alignment and writeback
module load_align (
    input  logic                 core_clock_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  lsu_pkg::load_stage_t stage_i,
    input  mem_pkg::dword_t      ram_data_i,
    output logic                 wb_valid_o,
    output lsu_pkg::load_wb_t    wb_o
);
    import lsu_pkg::*;
    import mem_pkg::*;

    word_t      half_word;
    word_t      merged;
    word_t      src;
    word_t      value;
    logic [1:0] lane;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;
    logic       sign_ext;

    logic     wr_en_q;
    rob_tag_t rob_q;
    preg_t    dest_q;
    word_t    data_q;

    assign half_word = stage_i.addr_lo[2] ? ram_data_i[63:32] : ram_data_i[31:0];

    // Store buffer bytes win over array bytes
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = stage_i.fwd_mask[b] ? stage_i.fwd_data[8*b +: 8]
                                                   : half_word[8*b +: 8];
        end
    end

    assign src = stage_i.io ? stage_i.fwd_data : merged;

    // I/O data already sits in the low bits
    assign lane     = stage_i.io ? 2'b00 : stage_i.addr_lo[1:0];
    assign sel_byte = src[8*lane +: 8];
    assign sel_half = lane[1] ? src[31:16] : src[15:0];
    assign sign_ext = !stage_i.op[OP_UNSIGNED];

    always_comb begin
        case (stage_i.op[1:0])
            SIZE_BYTE: value = {{24{sign_ext && sel_byte[7]}}, sel_byte};
            SIZE_HALF: value = {{16{sign_ext && sel_half[15]}}, sel_half};
            default:   value = src;
        endcase
    end

    always_ff @(posedge core_clock_i) begin
        if (!rst_n_i || flush_i) begin
            wb_valid_o <= 1'b0;
            wr_en_q    <= 1'b0;
        end else begin
            wb_valid_o <= stage_i.valid;
            wr_en_q    <= stage_i.valid && (stage_i.dest != '0);
        end
        rob_q  <= stage_i.rob;
        dest_q <= stage_i.dest;
        data_q <= value;
    end

    assign wb_o = '{rob: rob_q, dest: dest_q, data: data_q, wr_en: wr_en_q};

endmodule

// File: hw/load_queue.sv
// Load queue and miss handling
module load_queue #(
    parameter int WEAK_DEPTH   = 8,
    parameter int STRONG_DEPTH = 4
) (
    input  logic                  core_clock_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  in_valid_i,
    input  lsu_pkg::load_req_t    in_req_i,
    output logic                  stall_o,
    input  logic                  hit_i,
    output mem_pkg::line_addr_t   line_addr_o,
    output mem_pkg::ram_addr_t    ram_addr_o,
    output logic [29:0]           conflict_addr_o,
    output mem_pkg::byte_mask_t   conflict_mask_o,
    input  logic                  conflict_valid_i,
    input  logic                  conflict_ok_i,
    input  mem_pkg::word_t        conflict_data_i,
    input  lsu_pkg::oldest_tag_t  oldest_tag_i,
    input  logic                  store_buf_empty_i,
    output logic                  mem_req_o,
    output mem_pkg::mem_req_t     mem_req_info_o,
    input  logic                  mem_ack_i,
    input  mem_pkg::word_t        mem_data_i,
    output lsu_pkg::load_stage_t  stage_o
);
    import lsu_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } mem_state_e;

    mem_state_e state_q;
    logic       req_killed_q;
    logic       miss_valid_q;
    logic       refill_done_q;
    line_addr_t miss_line_q;

    load_req_t weak_head;
    load_req_t strong_head;
    load_req_t rd_req;
    load_req_t st_req;
    logic      weak_full;
    logic      weak_empty;
    logic      strong_full;
    logic      strong_empty;

    logic in_cached;
    logic in_miss;
    logic other_line;
    logic conflict_stall;
    logic forward;
    logic mem_ack_seen;
    logic io_done;
    logic refill_ack;
    logic replay_try;
    logic replay;
    logic io_ready;
    logic accept;
    logic take_hit;
    logic push_weak;
    logic push_strong;

    // Replay owns the array port once the line is in
    assign replay_try = miss_valid_q && refill_done_q && !weak_empty;
    assign rd_req     = replay_try ? weak_head : in_req_i;

    assign line_addr_o     = rd_req.addr[31:7];
    assign ram_addr_o      = rd_req.addr[11:3];
    assign conflict_addr_o = in_req_i.addr[31:2];
    assign conflict_mask_o = in_req_i.mask;

    // A killed request finishes its handshake without effect
    assign mem_ack_seen = state_q == REQ && mem_ack_i && !req_killed_q && !flush_i;
    assign io_done      = mem_ack_seen && mem_req_info_o.uncached;
    assign refill_ack   = mem_ack_seen && !mem_req_info_o.uncached;
    assign replay       = replay_try && hit_i && !io_done && !flush_i;

    assign in_cached  = !in_req_i.addr[IO_ADDR_BIT];
    assign in_miss    = in_cached && !hit_i;
    assign other_line = miss_valid_q && (in_req_i.addr[31:7] != miss_line_q);

    // Misses cannot carry forwarded bytes, so they wait as well
    assign conflict_stall = in_cached && conflict_valid_i && (in_miss || !conflict_ok_i);
    assign forward        = conflict_valid_i && conflict_ok_i;

    assign stall_o = in_valid_i && (io_done || replay_try || conflict_stall ||
                     (in_cached ? in_miss && (weak_full || other_line) : strong_full));

    assign accept      = in_valid_i && !stall_o && !flush_i;
    assign take_hit    = accept && in_cached && hit_i;
    assign push_weak   = accept && in_miss;
    assign push_strong = accept && !in_cached;

    // I/O goes out only at the ROB head with stores drained
    assign io_ready = !strong_empty && (strong_head.rob[4:0] == oldest_tag_i) &&
                      store_buf_empty_i;

    load_fifo #(
        .DEPTH (WEAK_DEPTH),
        .T     (load_req_t)
    ) weak_queue (
        .core_clock_i (core_clock_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_i       (push_weak),
        .push_data_i  (in_req_i),
        .pop_i        (replay),
        .full_o       (weak_full),
        .empty_o      (weak_empty),
        .head_o       (weak_head)
    );

    load_fifo #(
        .DEPTH (STRONG_DEPTH),
        .T     (load_req_t)
    ) strong_queue (
        .core_clock_i (core_clock_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_i       (push_strong),
        .push_data_i  (in_req_i),
        .pop_i        (io_done),
        .full_o       (strong_full),
        .empty_o      (strong_empty),
        .head_o       (strong_head)
    );

    // Miss stays open until its replays have drained
    always_ff @(posedge core_clock_i) begin
        if (!rst_n_i || flush_i) begin
            miss_valid_q  <= 1'b0;
            refill_done_q <= 1'b0;
        end else if (!miss_valid_q) begin
            miss_valid_q <= push_weak;
        end else if (refill_done_q && weak_empty && !push_weak) begin
            miss_valid_q  <= 1'b0;
            refill_done_q <= 1'b0;
        end else if (refill_ack) begin
            refill_done_q <= 1'b1;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (push_weak && !miss_valid_q) begin
            miss_line_q <= in_req_i.addr[31:7];
        end
    end

    // Four-phase request, I/O served before refill
    always_ff @(posedge core_clock_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            req_killed_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    req_killed_q <= 1'b0;
                    if (!flush_i && (io_ready || (miss_valid_q && !refill_done_q))) begin
                        state_q <= REQ;
                    end
                end
                REQ: begin
                    if (flush_i) begin
                        req_killed_q <= 1'b1;
                    end
                    if (mem_ack_i) begin
                        state_q <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!mem_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Frozen outside IDLE
    always_ff @(posedge core_clock_i) begin
        if (state_q == IDLE) begin
            if (io_ready) begin
                mem_req_info_o <= '{addr: strong_head.addr, uncached: 1'b1};
            end else begin
                mem_req_info_o <= '{addr: {miss_line_q, 7'd0}, uncached: 1'b0};
            end
        end
    end

    assign mem_req_o = state_q == REQ;

    assign st_req = io_done ? strong_head : rd_req;

    always_ff @(posedge core_clock_i) begin
        if (!rst_n_i || flush_i) begin
            stage_o.valid <= 1'b0;
        end else begin
            stage_o.valid <= io_done || replay || take_hit;
        end
        stage_o.rob      <= st_req.rob;
        stage_o.dest     <= st_req.dest;
        stage_o.op       <= st_req.op;
        stage_o.addr_lo  <= st_req.addr[2:0];
        stage_o.io       <= io_done;
        stage_o.fwd_mask <= (forward && !replay_try && !io_done) ? in_req_i.mask : '0;
        stage_o.fwd_data <= io_done ? mem_data_i : conflict_data_i;
    end

    // Request info holds until the memory acknowledges
    assert property (@(posedge core_clock_i) disable iff (!rst_n_i)
        mem_req_o && !mem_ack_i |=> $stable(mem_req_info_o));

endmodule

// File: hw/load_fifo.sv
// Load request FIFO
module load_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = lsu_pkg::load_req_t
) (
    input  logic core_clock_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output logic full_o,
    output logic empty_o,
    output T     head_o
);
    localparam int AW = $clog2(DEPTH);

    T mem_q [DEPTH];

    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;

    always_ff @(posedge core_clock_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q[AW-1:0]] <= push_data_i;
        end
    end

    assign empty_o = wr_ptr_q == rd_ptr_q;
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign head_o  = mem_q[rd_ptr_q[AW-1:0]];

    // Callers gate push and pop on the flags
    assert property (@(posedge core_clock_i) disable iff (!rst_n_i)
        !(push_i && full_o) && !(pop_i && empty_o));

endmodule

// File: hw/load_skid_buffer.sv
// Load issue skid buffer
module load_skid_buffer (
    input  logic               core_clock_i,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               in_valid_i,
    input  lsu_pkg::load_req_t in_req_i,
    input  logic               stall_i,
    output logic               busy_o,
    output logic               out_valid_o,
    output lsu_pkg::load_req_t out_req_o
);
    import lsu_pkg::*;

    logic      full_q;
    load_req_t held_q;

    // Capture on stall, release once the queue takes it
    always_ff @(posedge core_clock_i) begin
        if (!rst_n_i || flush_i) begin
            full_q <= 1'b0;
        end else if (!full_q) begin
            full_q <= in_valid_i && stall_i;
        end else if (!stall_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (!full_q) begin
            held_q <= in_req_i;
        end
    end

    // Held load goes first, issue waits on busy
    assign busy_o      = full_q;
    assign out_valid_o = full_q || in_valid_i;
    assign out_req_o   = full_q ? held_q : in_req_i;

endmodule

// File: hw/lsu_pkg.sv
// Load instruction types
package lsu_pkg;

    typedef logic [5:0] rob_tag_t;

    // Register 0 is never written
    typedef logic [5:0] preg_t;

    // Low two bits give the size, bit 2 selects zero extension
    typedef logic [2:0] load_op_t;

    // Compared with the low bits of rob_tag_t
    typedef logic [4:0] oldest_tag_t;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam int OP_UNSIGNED = 2;

    typedef struct packed {
        rob_tag_t            rob;
        load_op_t            op;
        mem_pkg::addr_t      addr;
        preg_t               dest;
        mem_pkg::byte_mask_t mask;
    } load_req_t;

    typedef struct packed {
        rob_tag_t       rob;
        preg_t          dest;
        mem_pkg::word_t data;
        logic           wr_en;
    } load_wb_t;

    // Between the array read and the writeback register
    typedef struct packed {
        logic                valid;
        rob_tag_t            rob;
        preg_t               dest;
        load_op_t            op;
        logic [2:0]          addr_lo;
        logic                io;
        mem_pkg::byte_mask_t fwd_mask;
        // Forwarded bytes, or the whole I/O word
        mem_pkg::word_t      fwd_data;
    } load_stage_t;

endpackage

// File: hw/mem_pkg.sv
// Memory side types
package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // One 64-bit word of the data array
    typedef logic [63:0] dword_t;

    typedef logic [3:0] byte_mask_t;

    // Address bits 31 to 7, lines are 128 bytes
    typedef logic [24:0] line_addr_t;

    // Address bits 11 to 3 index the array
    typedef logic [8:0] ram_addr_t;

    // Set in the address for uncached I/O space
    localparam int IO_ADDR_BIT = 31;

    // Refill uses a line base, I/O uses the load address
    typedef struct packed {
        addr_t addr;
        logic  uncached;
    } mem_req_t;

endpackage
